//--- list.f
+incdir+src
src/isa_pkg.sv
src/cpu_pkg.sv
src/if_stage.sv
src/decoder.sv
src/gpr.sv
src/alu.sv
src/mem_ctrl.sv
src/spm.sv
src/cpu_top.sv
verif/cpu_properties.sv
verif/cpu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the cpu_tb simulation with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb -f list.f -o cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/cpu_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- verif/cpu_tb.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_tb import cpu_pkg::*, isa_pkg::*; ();

    localparam int IMG_WORDS    = 128;     // program in 0..63, data in 64..127.
    localparam int DATA_BASE    = 64;
    localparam int DATA_BYTE    = 256;     // byte address of the data region.
    localparam int PORT_WORDS   = 32;
    localparam int HALT_TIMEOUT = 4000;    // cycles.
    localparam int REF_STEPS    = 4000;

    logic       clk;
    logic       arst_n;
    logic       cpu_en;
    word_addr_t test_spm_addr;
    logic       test_spm_en;
    logic       test_spm_we;
    word_t      test_spm_wr_data;
    word_t      test_spm_rd_data;
    logic       halted;
    logic       misalign;

    word_t image [IMG_WORDS];
    word_t expect_mem [IMG_WORDS];
    int    prog_len;
    int    err_count;
    int    check_count;
    int    test_count;
    int    fail_count;

    cpu_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ############################################################
    // instruction encoding and program image
    // ############################################################

    function automatic insn_t enc_r(input opcode_t op, input int rd, input int ra, input int rb);
        return {op, rd[4:0], ra[4:0], rb[4:0], 11'd0};
    endfunction

    function automatic insn_t enc_i(input opcode_t op, input int rd, input int ra, input int imm);
        return {op, rd[4:0], ra[4:0], imm[15:0]};
    endfunction

    task automatic emit(input insn_t w);
        image[prog_len] = w;
        prog_len++;
    endtask

    task automatic new_image();
        for (int i = 0; i < IMG_WORDS; i++) begin
            if (i < DATA_BASE) begin
                image[i] = enc_i(OP_HALT, 0, 0, i);   // unused slots halt.
            end else begin
                image[i] = $urandom;
            end
        end
        prog_len = 0;
    endtask

    // ############################################################
    // instruction-level reference
    // ############################################################

    function automatic bit ref_run();
        word_t    regs [`GPR_NUM];
        insn_t    w;
        reg_idx_t rd;
        reg_idx_t ra;
        reg_idx_t rb;
        word_t    va;
        word_t    vb;
        word_t    imm_x;
        word_t    ea;
        word_t    res;
        bit       wr;
        bit       done;
        bit       bad;
        int       pc;
        int       next_pc;
        done = 1'b0;
        bad  = 1'b0;
        pc   = 0;
        for (int i = 0; i < `GPR_NUM; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < IMG_WORDS; i++) begin
            expect_mem[i] = image[i];
        end
        for (int step = 0; step < REF_STEPS && !done; step++) begin
            w       = expect_mem[pc[6:0]];
            rd      = w[25:21];
            ra      = w[20:16];
            rb      = w[15:11];
            va      = regs[ra];
            vb      = regs[rb];
            imm_x   = {{16{w[15]}}, w[15:0]};
            ea      = va + imm_x;
            res     = '0;
            wr      = 1'b0;
            next_pc = pc + 1;
            case (w[31:26])
                OP_ADD:  begin res = va + vb;        wr = 1'b1; end
                OP_SUB:  begin res = va - vb;        wr = 1'b1; end
                OP_AND:  begin res = va & vb;        wr = 1'b1; end
                OP_OR:   begin res = va | vb;        wr = 1'b1; end
                OP_XOR:  begin res = va ^ vb;        wr = 1'b1; end
                OP_SHL:  begin res = va << vb[4:0];  wr = 1'b1; end
                OP_SHR:  begin res = va >> vb[4:0];  wr = 1'b1; end
                OP_ADDI: begin res = va + imm_x;     wr = 1'b1; end
                OP_LDW: begin
                    if (ea[1:0] != 2'b00) begin
                        bad = 1'b1;
                    end else begin
                        res = expect_mem[ea[8:2]];
                        wr  = 1'b1;
                    end
                end
                OP_STW: begin
                    if (ea[1:0] != 2'b00) begin
                        bad = 1'b1;
                    end else begin
                        expect_mem[ea[8:2]] = regs[rd];
                    end
                end
                OP_BEQ: begin
                    if (va == regs[rd]) begin
                        next_pc = pc + 1 + int'(imm_x);
                    end
                end
                OP_BNE: begin
                    if (va != regs[rd]) begin
                        next_pc = pc + 1 + int'(imm_x);
                    end
                end
                OP_HALT: done = 1'b1;
                default: ;                    // unlisted codes act as nop.
            endcase
            if (wr && rd != 0) begin
                regs[rd] = res;
            end
            pc = next_pc;
        end
        return bad;
    endfunction

    // ############################################################
    // test port, reset and checking
    // ############################################################

    task automatic apply_reset();
        cpu_en = 1'b0;
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;
    endtask

    task automatic spm_write(input int addr, input word_t data);
        @(posedge clk);
        #2;
        test_spm_addr    = word_addr_t'(addr);
        test_spm_wr_data = data;
        test_spm_en      = 1'b1;
        test_spm_we      = 1'b1;
        @(posedge clk);
        #2;
        test_spm_en      = 1'b0;
        test_spm_we      = 1'b0;
    endtask

    task automatic spm_read(input int addr, output word_t data);
        @(posedge clk);
        #2;
        test_spm_addr = word_addr_t'(addr);
        test_spm_en   = 1'b1;
        @(posedge clk);
        #2;
        test_spm_en   = 1'b0;
        data          = test_spm_rd_data;     // held while the port is idle.
    endtask

    task automatic compare(input string what, input word_t expected, input word_t actual);
        check_count++;
        if (expected !== actual) begin
            err_count++;
            $display("[FAIL] %s expected %08h actual %08h", what, expected, actual);
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        test_count++;
        if (err_count == errs_at_start) begin
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: FAILED with %0d errors", name, err_count - errs_at_start);
        end
    endtask

    task automatic run_program(input string name);
        bit    exp_mis;
        int    errs_at_start;
        int    cycles;
        word_t got;
        errs_at_start = err_count;
        exp_mis       = ref_run();
        apply_reset();
        for (int i = 0; i < IMG_WORDS; i++) begin
            spm_write(i, image[i]);
        end
        @(posedge clk);
        #2;
        cpu_en = 1'b1;
        cycles = 0;
        while (halted !== 1'b1 && cycles < HALT_TIMEOUT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("timeout: core did not halt within %0d cycles in test %s",
                     HALT_TIMEOUT, name);
            err_count++;
        end
        cpu_en = 1'b0;
        for (int i = DATA_BASE; i < IMG_WORDS; i++) begin
            spm_read(i, got);
            compare($sformatf("%s word %0d", name, i), expect_mem[i], got);
        end
        compare({name, " misalign"}, word_t'(exp_mis), word_t'(misalign));
        finish_test(name, errs_at_start);
    endtask

    task automatic port_isolation();
        word_t written [PORT_WORDS];
        word_t got;
        int    errs_at_start;
        errs_at_start = err_count;
        for (int i = 0; i < PORT_WORDS; i++) begin
            written[i] = $urandom;
            spm_write(512 + i * 7, written[i]);
        end
        for (int i = 0; i < PORT_WORDS; i++) begin
            spm_read(512 + i * 7, got);
            compare($sformatf("port word %0d", 512 + i * 7), written[i], got);
        end
        finish_test("port", errs_at_start);
    endtask

    // ############################################################
    // programs
    // ############################################################

    task automatic build_arith();
        new_image();
        emit(enc_i(OP_ADDI, 1, 0, DATA_BYTE));
        emit(enc_i(OP_LDW, 2, 1, 0));
        emit(enc_i(OP_LDW, 3, 1, 4));
        emit(enc_r(OP_ADD, 4, 2, 3));
        emit(enc_r(OP_SUB, 5, 2, 3));
        emit(enc_r(OP_AND, 6, 2, 3));
        emit(enc_r(OP_OR, 7, 2, 3));
        emit(enc_r(OP_XOR, 8, 2, 3));
        emit(enc_r(OP_SHL, 9, 2, 3));
        emit(enc_r(OP_SHR, 10, 2, 3));
        emit(enc_i(OP_ADDI, 11, 2, int'($urandom)));
        for (int k = 4; k <= 11; k++) begin
            emit(enc_i(OP_STW, k, 1, 4 * k + 32));
        end
        emit(enc_i(OP_HALT, 0, 0, 0));
    endtask

    task automatic build_forward();
        new_image();
        emit(enc_i(OP_ADDI, 1, 0, DATA_BYTE));
        emit(enc_i(OP_LDW, 2, 1, 0));
        emit(enc_i(OP_ADDI, 9, 0, int'($urandom)));
        emit(enc_r(OP_ADD, 3, 2, 9));          // distance one on r9.
        emit(enc_r(OP_SUB, 4, 3, 2));
        emit(enc_r(OP_XOR, 5, 3, 4));          // distances two and one.
        emit(enc_r(OP_SHR, 6, 5, 3));
        emit(enc_i(OP_ADDI, 7, 6, int'($urandom)));
        emit(enc_i(OP_STW, 7, 1, 16));         // store data straight from execute.
        emit(enc_i(OP_STW, 3, 1, 20));
        emit(enc_i(OP_STW, 4, 1, 24));
        emit(enc_i(OP_STW, 5, 1, 28));
        emit(enc_i(OP_STW, 6, 1, 32));
        emit(enc_i(OP_HALT, 0, 0, 0));
    endtask

    task automatic build_load_use();
        new_image();
        emit(enc_i(OP_ADDI, 1, 0, DATA_BYTE));
        emit(enc_i(OP_LDW, 2, 1, 0));
        emit(enc_r(OP_ADD, 3, 2, 2));
        emit(enc_i(OP_LDW, 4, 1, 4));
        emit(enc_i(OP_STW, 4, 1, 32));
        emit(enc_i(OP_LDW, 5, 1, 8));
        emit(enc_i(OP_BNE, 5, 2, 1));          // branch on a fresh load.
        emit(enc_i(OP_ADDI, 6, 0, 77));
        emit(enc_i(OP_LDW, 7, 1, 12));
        emit(enc_i(OP_ADDI, 8, 7, 5));
        emit(enc_i(OP_STW, 3, 1, 36));
        emit(enc_i(OP_STW, 6, 1, 40));
        emit(enc_i(OP_STW, 8, 1, 44));
        emit(enc_i(OP_HALT, 0, 0, 0));
    endtask

    task automatic build_branch();
        new_image();
        emit(enc_i(OP_ADDI, 1, 0, DATA_BYTE));
        emit(enc_i(OP_ADDI, 2, 0, int'($urandom_range(8, 1))));
        emit(enc_i(OP_ADDI, 3, 0, 0));
        emit(enc_i(OP_ADDI, 4, 0, 0));
        emit(enc_i(OP_ADDI, 3, 3, 1));         // loop head.
        emit(enc_r(OP_ADD, 4, 4, 3));
        emit(enc_i(OP_BNE, 2, 3, -3));
        emit(enc_i(OP_ADDI, 5, 5, 1));         // squashed while the loop runs.
        emit(enc_i(OP_BEQ, 2, 3, 1));
        emit(enc_i(OP_ADDI, 6, 0, 99));
        emit(enc_i(OP_ADDI, 7, 0, 7));
        emit(enc_i(OP_BEQ, 2, 0, 1));
        emit(enc_i(OP_ADDI, 8, 0, 55));
        for (int k = 3; k <= 8; k++) begin
            emit(enc_i(OP_STW, k, 1, 4 * k));
        end
        emit(enc_i(OP_HALT, 0, 0, 0));
    endtask

    task automatic build_misalign();
        new_image();
        emit(enc_i(OP_ADDI, 1, 0, DATA_BYTE));
        emit(enc_i(OP_ADDI, 2, 0, int'($urandom)));
        emit(enc_i(OP_ADDI, 3, 0, 32'h123));
        emit(enc_i(OP_STW, 2, 1, 2));
        emit(enc_i(OP_STW, 2, 1, 4));
        emit(enc_i(OP_LDW, 3, 1, 9));
        emit(enc_i(OP_STW, 3, 1, 8));
        emit(enc_i(OP_LDW, 4, 1, 4));
        emit(enc_i(OP_STW, 4, 1, 12));
        emit(enc_i(OP_HALT, 0, 0, 0));
    endtask

    initial begin
        arst_n           = 1'b0;
        cpu_en           = 1'b0;
        test_spm_addr    = '0;
        test_spm_en      = 1'b0;
        test_spm_we      = 1'b0;
        test_spm_wr_data = '0;
        err_count        = 0;
        check_count      = 0;
        test_count       = 0;
        fail_count       = 0;
        void'($urandom(11));
        apply_reset();
        port_isolation();
        build_arith();
        run_program("arith");
        build_forward();
        run_program("forward");
        build_load_use();
        run_program("load_use");
        build_branch();
        run_program("branch");
        build_misalign();
        run_program("misalign");
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, fail_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- verif/cpu_properties.sv
`timescale 1ns/100ps

module cpu_properties import cpu_pkg::*; (
    input logic     clk,
    input logic     arst_n,
    input logic     cpu_en,
    input logic     halted,
    input logic     if_en,
    input logic     ex_valid,
    input mem_op_t  ex_mem_op,
    input word_t    alu_out,
    input logic     spm_b_we,
    input logic     wb_we,
    input reg_idx_t wb_dst
);

    logic bad_access;

    // core-side access whose byte address is not on a word boundary.
    assign bad_access = cpu_en && ex_valid && (ex_mem_op != MEM_NONE) && (alu_out[1:0] != 2'b00);

    a_quiet_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !halted && !if_en)
        else $error("halted or if_en high right after reset.");

    a_no_misaligned_write: assert property (
        @(posedge clk) disable iff (!arst_n) bad_access |-> !spm_b_we)
        else $error("port b written by a misaligned store.");

    a_r0_never_written: assert property (@(posedge clk) disable iff (!arst_n) wb_we |-> wb_dst != '0)
        else $error("register file write aimed at r0.");

    a_no_fetch_halted: assert property (@(posedge clk) disable iff (!arst_n) halted |-> !if_en)
        else $error("fetch enabled after halt.");

endmodule

bind cpu_top cpu_properties u_cpu_properties (
    .clk       (clk),
    .arst_n    (arst_n),
    .cpu_en    (cpu_en),
    .halted    (halted),
    .if_en     (if_en),
    .ex_valid  (ex_valid),
    .ex_mem_op (ex_mem_op),
    .alu_out   (alu_out),
    .spm_b_we  (spm_b_we),
    .wb_we     (wb_we),
    .wb_dst    (wb_dst)
);

//--- src/cpu_top.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_top import cpu_pkg::*, isa_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cpu_en,
    input  word_addr_t test_spm_addr,
    input  logic       test_spm_en,
    input  logic       test_spm_we,
    input  word_t      test_spm_wr_data,
    output word_t      test_spm_rd_data,
    output logic       halted,
    output logic       misalign
);

    // fetch
    word_addr_t if_pc;
    logic       if_en;
    logic       if_valid;
    insn_t      insn;
    insn_t      if_insn;

    // decode
    logic       stall;
    logic       br_taken;
    word_addr_t br_addr;
    logic       halt_seen;
    reg_idx_t   gpr_rd_addr_0;
    reg_idx_t   gpr_rd_addr_1;
    word_t      gpr_rd_data_0;
    word_t      gpr_rd_data_1;

    // execute
    alu_op_t    alu_op;
    word_t      alu_in_0;
    word_t      alu_in_1;
    word_t      alu_out;
    reg_idx_t   ex_dst;
    logic       ex_we;
    logic       ex_is_load;
    mem_op_t    ex_mem_op;
    word_t      ex_store_data;
    logic       ex_halt;
    logic       ex_valid;

    // data side and writeback
    word_addr_t mem_addr;
    logic       mem_en;
    logic       mem_we;
    word_t      mem_wr_data;
    word_t      mem_rd_data;
    logic       wb_we;
    reg_idx_t   wb_dst;
    word_t      wb_data;

    logic [`SPM_ADDR_W-1:0] spm_b_addr;
    logic                   spm_b_en;
    logic                   spm_b_we;
    word_t                  spm_b_wr_data;

    // ############################################################
    // pipeline
    // ############################################################

    if_stage u_if_stage (.*);

    decoder u_decoder (.*);

    assign ex_is_load = (ex_mem_op == MEM_LOAD);

    gpr u_gpr (
        .clk       (clk),
        .arst_n    (arst_n),
        .we        (wb_we),
        .wr_addr   (wb_dst),
        .wr_data   (wb_data),
        .rd_addr_0 (gpr_rd_addr_0),
        .rd_addr_1 (gpr_rd_addr_1),
        .rd_data_0 (gpr_rd_data_0),
        .rd_data_1 (gpr_rd_data_1)
    );

    alu u_alu (.*);

    mem_ctrl u_mem_ctrl (.*);

    // ############################################################
    // scratch-pad and test port
    // ############################################################

    spm u_spm (
        .clk       (clk),
        .a_addr    (if_pc[`SPM_ADDR_W-1:0]),
        .a_en      (if_en),
        .b_addr    (spm_b_addr),
        .b_en      (spm_b_en),
        .b_we      (spm_b_we),
        .b_wr_data (spm_b_wr_data),
        .a_rd_data (insn),
        .b_rd_data (mem_rd_data)
    );

    // port b belongs to the test port while the core is off.
    assign spm_b_addr       = cpu_en ? mem_addr[`SPM_ADDR_W-1:0] :
                                       test_spm_addr[`SPM_ADDR_W-1:0];
    assign spm_b_en         = cpu_en ? mem_en      : test_spm_en;
    assign spm_b_we         = cpu_en ? mem_we      : test_spm_we;
    assign spm_b_wr_data    = cpu_en ? mem_wr_data : test_spm_wr_data;
    assign test_spm_rd_data = cpu_en ? '0 : mem_rd_data;

endmodule

//--- src/spm.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module spm import cpu_pkg::*; (
    input  logic                   clk,
    input  logic [`SPM_ADDR_W-1:0] a_addr,
    input  logic                   a_en,
    input  logic [`SPM_ADDR_W-1:0] b_addr,
    input  logic                   b_en,
    input  logic                   b_we,
    input  word_t                  b_wr_data,
    output word_t                  a_rd_data,
    output word_t                  b_rd_data
);

    word_t mem [`SPM_DEPTH];

    // port a, fetch only. output holds while a_en is low.
    always_ff @(posedge clk) begin
        if (a_en) begin
            a_rd_data <= mem[a_addr];
        end
    end

    // port b, read before write.
    always_ff @(posedge clk) begin
        if (b_en) begin
            if (b_we) begin
                mem[b_addr] <= b_wr_data;
            end
            b_rd_data <= mem[b_addr];
        end
    end

endmodule

//--- src/mem_ctrl.sv
`timescale 1ns/100ps

module mem_ctrl import cpu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       ex_valid,
    input  mem_op_t    ex_mem_op,
    input  reg_idx_t   ex_dst,
    input  logic       ex_we,
    input  word_t      ex_store_data,
    input  logic       ex_halt,
    input  word_t      alu_out,
    input  word_t      mem_rd_data,
    output word_addr_t mem_addr,
    output logic       mem_en,
    output logic       mem_we,
    output word_t      mem_wr_data,
    output logic       wb_we,
    output reg_idx_t   wb_dst,
    output word_t      wb_data,
    output logic       halted,
    output logic       misalign
);

    byte_addr_t acc_addr;
    logic       acc_req;
    logic       acc_bad;
    logic       wb_load;
    word_t      wb_alu;

    assign acc_addr    = alu_out;
    assign acc_req     = ex_valid && (ex_mem_op != MEM_NONE);
    assign acc_bad     = acc_req && (acc_addr[1:0] != 2'b00);
    assign mem_addr    = acc_addr[$bits(byte_addr_t)-1:2];
    assign mem_en      = acc_req && !acc_bad;  // misaligned access never reaches the spm.
    assign mem_we      = mem_en && (ex_mem_op == MEM_STORE);
    assign mem_wr_data = ex_store_data;

    // ############################################################
    // writeback register
    // ############################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_we    <= 1'b0;
            wb_load  <= 1'b0;
            halted   <= 1'b0;
            misalign <= 1'b0;
        end else begin
            wb_we    <= ex_valid && ex_we && !acc_bad;
            wb_load  <= mem_en && (ex_mem_op == MEM_LOAD);
            halted   <= halted || (ex_valid && ex_halt);
            misalign <= misalign || acc_bad;   // sticky until reset.
        end
    end

    always_ff @(posedge clk) begin
        wb_dst <= ex_dst;
        wb_alu <= alu_out;
    end

    // load data lands one cycle after the access.
    assign wb_data = wb_load ? mem_rd_data : wb_alu;

endmodule

//--- src/alu.sv
`timescale 1ns/100ps

module alu import cpu_pkg::*, isa_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   alu_in_0,
    input  word_t   alu_in_1,
    output word_t   alu_out
);

    always_comb begin
        case (alu_op)
            ALU_PASS: alu_out = alu_in_0;
            ALU_ADD:  alu_out = alu_in_0 + alu_in_1;
            ALU_SUB:  alu_out = alu_in_0 - alu_in_1;
            ALU_AND:  alu_out = alu_in_0 & alu_in_1;
            ALU_OR:   alu_out = alu_in_0 | alu_in_1;
            ALU_XOR:  alu_out = alu_in_0 ^ alu_in_1;
            ALU_SHL:  alu_out = alu_in_0 << alu_in_1[4:0];   // low 5 bits only.
            ALU_SHR:  alu_out = alu_in_0 >> alu_in_1[4:0];   // logical.
            default:  alu_out = '0;
        endcase
    end

endmodule

//--- src/gpr.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module gpr import cpu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     we,
    input  reg_idx_t wr_addr,
    input  word_t    wr_data,
    input  reg_idx_t rd_addr_0,
    input  reg_idx_t rd_addr_1,
    output word_t    rd_data_0,
    output word_t    rd_data_1
);

    word_t regs [`GPR_NUM];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `GPR_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;          // r0 is never written.
        end
    end

    assign rd_data_0 = (rd_addr_0 == '0) ? '0 : regs[rd_addr_0];
    assign rd_data_1 = (rd_addr_1 == '0) ? '0 : regs[rd_addr_1];

endmodule

//--- src/decoder.sv
`timescale 1ns/100ps

module decoder import cpu_pkg::*, isa_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  insn_t      if_insn,
    input  word_addr_t if_pc,
    input  logic       if_valid,
    input  word_t      gpr_rd_data_0,
    input  word_t      gpr_rd_data_1,
    input  logic       ex_is_load,
    input  word_t      alu_out,
    input  reg_idx_t   wb_dst,
    input  logic       wb_we,
    input  word_t      wb_data,
    output reg_idx_t   gpr_rd_addr_0,
    output reg_idx_t   gpr_rd_addr_1,
    output logic       stall,
    output logic       br_taken,
    output word_addr_t br_addr,
    output logic       halt_seen,
    output alu_op_t    alu_op,
    output word_t      alu_in_0,
    output word_t      alu_in_1,
    output reg_idx_t   ex_dst,
    output logic       ex_we,
    output mem_op_t    ex_mem_op,
    output word_t      ex_store_data,
    output logic       ex_halt,
    output logic       ex_valid
);

    opcode_t  op;
    reg_idx_t rd;
    reg_idx_t ra;
    reg_idx_t rb;
    imm_t     imm;
    word_t    imm_ext;
    word_t    opr_a;
    word_t    opr_b;
    logic     use_a;
    logic     use_b;
    logic     use_imm;
    logic     src_rd;
    logic     dec_we;
    logic     issue;
    alu_op_t  dec_alu_op;
    mem_op_t  dec_mem_op;

    // ############################################################
    // fields and operand select
    // ############################################################

    assign op      = opcode_t'(if_insn[OPC_LSB +: OPC_W]);
    assign rd      = if_insn[RD_LSB +: REG_W];
    assign ra      = if_insn[RA_LSB +: REG_W];
    assign rb      = if_insn[RB_LSB +: REG_W];
    assign imm     = if_insn[$bits(imm_t)-1:0];
    assign imm_ext = {{16{imm[15]}}, imm};

    always_comb begin
        dec_alu_op = ALU_PASS;
        dec_mem_op = MEM_NONE;
        dec_we     = 1'b0;
        use_a      = 1'b0;
        use_b      = 1'b0;
        use_imm    = 1'b0;
        src_rd     = 1'b0;
        case (op)
            OP_ADD:  dec_alu_op = ALU_ADD;
            OP_SUB:  dec_alu_op = ALU_SUB;
            OP_AND:  dec_alu_op = ALU_AND;
            OP_OR:   dec_alu_op = ALU_OR;
            OP_XOR:  dec_alu_op = ALU_XOR;
            OP_SHL:  dec_alu_op = ALU_SHL;
            OP_SHR:  dec_alu_op = ALU_SHR;
            OP_ADDI, OP_LDW, OP_STW: dec_alu_op = ALU_ADD;   // address or sum.
            default: dec_alu_op = ALU_PASS;
        endcase
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR: begin
                use_a  = 1'b1;
                use_b  = 1'b1;
                dec_we = 1'b1;
            end
            OP_ADDI, OP_LDW: begin
                use_a      = 1'b1;
                use_imm    = 1'b1;
                dec_we     = 1'b1;
                dec_mem_op = (op == OP_LDW) ? MEM_LOAD : MEM_NONE;
            end
            OP_STW: begin
                use_a      = 1'b1;
                use_b      = 1'b1;
                use_imm    = 1'b1;
                src_rd     = 1'b1;
                dec_mem_op = MEM_STORE;
            end
            OP_BEQ, OP_BNE: begin
                use_a  = 1'b1;
                use_b  = 1'b1;
                src_rd = 1'b1;                 // compare ra with rd.
            end
            default: ;                         // nop, halt, unlisted codes.
        endcase
    end

    assign gpr_rd_addr_0 = ra;
    assign gpr_rd_addr_1 = src_rd ? rd : rb;

    // execute wins over writeback, it is the younger result.
    assign opr_a = (ex_we && ex_dst == ra)            ? alu_out :
                   (wb_we && wb_dst == ra)            ? wb_data : gpr_rd_data_0;
    assign opr_b = (ex_we && ex_dst == gpr_rd_addr_1) ? alu_out :
                   (wb_we && wb_dst == gpr_rd_addr_1) ? wb_data : gpr_rd_data_1;

    // ############################################################
    // hazards and branches
    // ############################################################

    assign stall = if_valid && ex_is_load && ex_we &&
                   ((use_a && ra == ex_dst) || (use_b && gpr_rd_addr_1 == ex_dst));

    assign br_taken  = if_valid && !stall &&
                       ((op == OP_BEQ && opr_a == opr_b) || (op == OP_BNE && opr_a != opr_b));
    assign br_addr   = if_pc + word_addr_t'(imm_ext);   // if_pc is already pc + 1.
    assign halt_seen = if_valid && (op == OP_HALT);
    assign issue     = if_valid && !stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid  <= 1'b0;
            ex_we     <= 1'b0;
            ex_mem_op <= MEM_NONE;
            ex_halt   <= 1'b0;
        end else begin
            ex_valid  <= issue;                // bubble on stall or empty slot.
            ex_we     <= issue && dec_we && (rd != '0);
            ex_mem_op <= issue ? dec_mem_op : MEM_NONE;
            ex_halt   <= issue && (op == OP_HALT);
        end
    end

    always_ff @(posedge clk) begin
        alu_op        <= dec_alu_op;
        alu_in_0      <= opr_a;
        alu_in_1      <= use_imm ? imm_ext : opr_b;
        ex_dst        <= rd;
        ex_store_data <= opr_b;
    end

endmodule

//--- src/if_stage.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"

module if_stage import cpu_pkg::*, isa_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cpu_en,
    input  logic       stall,
    input  logic       br_taken,
    input  word_addr_t br_addr,
    input  logic       halt_seen,
    input  insn_t      insn,
    output word_addr_t if_pc,
    output logic       if_en,
    output insn_t      if_insn,
    output logic       if_valid
);

    logic fetch_stop;

    // a stalled fetch keeps the spm output, so decode holds its word.
    assign if_en   = cpu_en && !fetch_stop && !stall;
    assign if_insn = if_valid ? insn : '0;     // squashed slot decodes as nop.

    // if_pc runs one word ahead of the instruction in decode.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_pc      <= word_addr_t'(`RESET_PC);
            if_valid   <= 1'b0;
            fetch_stop <= 1'b0;
        end else begin
            if (halt_seen) begin
                fetch_stop <= 1'b1;
            end
            if (br_taken || halt_seen) begin
                if_valid <= 1'b0;              // drop the word in flight.
                if (br_taken) begin
                    if_pc <= br_addr;
                end
            end else if (if_en) begin
                if_pc    <= if_pc + word_addr_t'(1);
                if_valid <= 1'b1;
            end else if (!stall) begin
                if_valid <= 1'b0;
            end
        end
    end

endmodule

//--- src/cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

    // ############################################################
    // datapath types
    // ############################################################

    typedef logic [`DATA_W-1:0]          word_t;
    typedef logic [`DATA_W-3:0]          word_addr_t;   // byte address without bits 1:0.
    typedef logic [`DATA_W-1:0]          byte_addr_t;
    typedef logic [$clog2(`GPR_NUM)-1:0] reg_idx_t;

    // data-side access kind.
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_t;

endpackage

//--- src/isa_pkg.sv
package isa_pkg;

    // ############################################################
    // instruction word
    // ############################################################

    typedef logic [31:0]        insn_t;
    typedef logic signed [15:0] imm_t;     // imm sits in bits 15:0.

    localparam int OPC_LSB = 26;           // opcode in 31:26.
    localparam int OPC_W   = 6;
    localparam int RD_LSB  = 21;           // rd in 25:21.
    localparam int RA_LSB  = 16;           // ra in 20:16.
    localparam int RB_LSB  = 11;           // rb in 15:11.
    localparam int REG_W   = 5;

    typedef enum logic [5:0] {
        OP_NOP  = 6'd0,
        OP_ADD  = 6'd1,
        OP_SUB  = 6'd2,
        OP_AND  = 6'd3,
        OP_OR   = 6'd4,
        OP_XOR  = 6'd5,
        OP_SHL  = 6'd6,
        OP_SHR  = 6'd7,
        OP_ADDI = 6'd8,
        OP_LDW  = 6'd9,
        OP_STW  = 6'd10,
        OP_BEQ  = 6'd11,
        OP_BNE  = 6'd12,
        OP_HALT = 6'd63
    } opcode_t;

    // ############################################################
    // alu operations
    // ############################################################

    typedef enum logic [3:0] {
        ALU_PASS,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SHL,
        ALU_SHR
    } alu_op_t;

endpackage

//--- src/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// ############################################################
// datapath and register file
// ############################################################

`define DATA_W      32      // data word width.
`define GPR_NUM     32      // general registers, r0 reads zero.

// ############################################################
// scratch-pad memory and fetch
// ############################################################

`define SPM_DEPTH   1024    // words.
`define SPM_ADDR_W  10      // log2 of depth.
`define RESET_PC    0       // first fetch, word address.

`endif
